// ==== fill_tests.txt ====
# One job per line, all fields hex
# mode colour base x_off y_off x_len y_len expected_write_count
0 abcd 000000 000 000 001 001 001
0 1234 010000 005 003 004 003 00c
1 0000 000000 000 000 010 002 020
1 ffff 100000 020 010 007 005 023
0 f00f fff000 3ff 3ff 003 004 00c
1 5a5a 200000 100 040 001 00a 00a
0 0f0f 300000 000 100 00c 001 00c
1 0001 000100 010 020 003 003 009
0 7e7e 123456 0ff 001 002 002 004
1 aaaa 0000ff 001 001 00f 003 02d
0 c3c3 400000 000 000 020 001 020
1 3c3c 00f00f 3e0 200 008 008 040
0 0000 000000 001 001 002 001 002
1 9999 000000 000 000 001 001 001
0 ffff 7fffff 3ff 000 005 002 00a
1 1357 055555 155 0aa 00b 004 02c

// ==== build.f ====
+incdir+.
fill_pkg.sv
fill_fsm.sv
rect_counter.sv
fill_addr_gen.sv
fill_pattern.sv
rect_fill_top.sv
tb_rect_fill.sv

// ==== tb_rect_fill.sv ====
// Testbench for the rectangle fill engine with file-driven jobs, memory responder and checks
`timescale 1ns/1ps
`default_nettype none

`include "fill_consts.svh"

module tb_rect_fill;

	localparam int AW = `FILL_ADDR_W;
	localparam int DW = `FILL_DATA_W;
	localparam int LFSR_W = 18;

	// DUT ports
	logic                 clkSYS;
	logic                 n_reset;
	logic                 start;
	logic                 ack;
	fill_pkg::fill_cfg_t  cfg;
	logic                 busy;
	logic                 done;
	logic                 req;
	fill_pkg::fill_wr_t   wr_word;

	// Reference model of the running job
	fill_pkg::fill_cfg_t  model_cfg;
	int                   model_row;
	int                   model_col;
	logic [LFSR_W - 1:0]  model_lfsr;
	int                   wr_count;
	int                   job_count;

	// Memory responder state
	logic                 pending;
	int                   ack_delay;
	fill_pkg::fill_wr_t   held_word;

	rect_fill_top DUT (
		.clkSYS,
		.n_reset,
		.start,
		.ack,
		.cfg,
		.busy,
		.done,
		.req,
		.wr_word
	);

	// 20 ns clock
	always #10 clkSYS = ~clkSYS;

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_error(input string why);
		$display("%s", why);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// One LFSR step shifts left and feeds the XNOR of bits 17 and 10 into bit 0
	function automatic logic [LFSR_W - 1:0] lfsr_next(input logic [LFSR_W - 1:0] s);
		return {s[LFSR_W - 2:0], ~(s[17] ^ s[10])};
	endfunction

	// Word address of one pixel of the rectangle
	function automatic logic [AW - 1:0] expected_addr(input fill_pkg::fill_cfg_t c,
		input int row, input int col);
		longint sum;
		sum = longint'(c.base)
			+ (longint'(c.y_off) + row) * `FILL_LINE_SIZE
			+ longint'(c.x_off) + col;
		return sum[AW - 1:0];
	endfunction

	function automatic logic [DW - 1:0] expected_data(input fill_pkg::fill_cfg_t c,
		input logic [LFSR_W - 1:0] s);
		if (c.mode == fill_pkg::FILL_PATTERN)
			return s[17:2];
		return c.colour;
	endfunction

	// Compare one acknowledged write with the model and advance row-major
	task automatic accept_write(input fill_pkg::fill_wr_t w);
		check_value("wr_word.addr", w.addr, expected_addr(model_cfg, model_row, model_col));
		check_value("wr_word.data", w.data, expected_data(model_cfg, model_lfsr));
		model_lfsr = lfsr_next(model_lfsr);
		wr_count = wr_count + 1;
		if (model_col == model_cfg.x_len - 1) begin
			model_col = 0;
			model_row = model_row + 1;
		end else begin
			model_col = model_col + 1;
		end
	endtask

	// Memory model that answers each request after 0 to 7 cycles
	initial begin
		void'($urandom(32'h3954_44e6));
		forever begin
			@(posedge clkSYS);
			if (!n_reset) begin
				ack <= 1'b0;
				pending = 1'b0;
			end else if (ack) begin
				// Ack is a single-cycle pulse
				check_value("req", req, 1'b1);
				ack <= 1'b0;
			end else if (req) begin
				if (!pending) begin
					if (wr_count >= job_count)
						report_error("write request beyond the expected count");
					pending = 1'b1;
					held_word = wr_word;
					ack_delay = $urandom % 8;
				end
				check_value("busy", busy, 1'b1);
				// Word must not move while waiting for ack
				check_value("wr_word", wr_word, held_word);
				if (ack_delay == 0) begin
					accept_write(wr_word);
					ack <= 1'b1;
					pending = 1'b0;
				end else begin
					ack_delay = ack_delay - 1;
				end
			end else if (pending) begin
				report_error("request dropped before ack");
			end
		end
	end

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clkSYS);
			check_value("req", req, 1'b0);
			check_value("busy", busy, 1'b0);
			check_value("done", done, 1'b0);
		end
	endtask

	task automatic wait_for_req(input int limit);
		int cycles;
		cycles = 0;
		while (!req) begin
			@(posedge clkSYS);
			cycles = cycles + 1;
			if (cycles > limit)
				report_error("no request within timeout");
		end
	endtask

	task automatic wait_for_writes(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (wr_count < count) begin
			@(posedge clkSYS);
			cycles = cycles + 1;
			if (cycles > limit)
				report_error("writes not acknowledged within timeout");
		end
	endtask

	task automatic wait_for_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done) begin
			@(posedge clkSYS);
			cycles = cycles + 1;
			if (cycles > limit)
				report_error("no done pulse within timeout");
		end
	endtask

	// Run one job from start pulse to done with a stray start in longer jobs
	task automatic run_job(input fill_pkg::fill_cfg_t job, input int exp_count);
		int limit;
		limit = exp_count * 12 + 50;
		model_cfg = job;
		model_row = 0;
		model_col = 0;
		model_lfsr = '0;
		wr_count = 0;
		job_count = exp_count;

		@(posedge clkSYS);
		cfg <= job;
		start <= 1'b1;
		@(posedge clkSYS);
		start <= 1'b0;
		// Config only matters in the start cycle
		cfg <= fill_pkg::fill_cfg_t'(~job);

		wait_for_req(10);
		check_value("busy", busy, 1'b1);
		check_value("done", done, 1'b0);

		if (exp_count >= 3) begin
			// Start while busy with a different config
			wait_for_writes(1, limit);
			start <= 1'b1;
			@(posedge clkSYS);
			check_value("busy", busy, 1'b1);
			start <= 1'b0;
		end

		wait_for_done(limit);
		check_value("write count", wr_count, exp_count);
		check_value("busy", busy, 1'b0);
		check_value("req", req, 1'b0);
		@(posedge clkSYS);
		check_value("done", done, 1'b0);
		check_value("busy", busy, 1'b0);
		cfg <= '0;
	endtask

	initial begin
		int                   fd;
		int                   fields;
		int                   jobs;
		string                line;
		logic [31:0]          f_mode;
		logic [31:0]          f_colour;
		logic [31:0]          f_base;
		logic [31:0]          f_x_off;
		logic [31:0]          f_y_off;
		logic [31:0]          f_x_len;
		logic [31:0]          f_y_len;
		logic [31:0]          f_count;
		fill_pkg::fill_cfg_t  job;

		clkSYS = 1'b0;
		n_reset = 1'b0;
		start = 1'b0;
		ack = 1'b0;
		cfg = '0;
		pending = 1'b0;
		wr_count = 0;
		job_count = 0;

		repeat (5) @(posedge clkSYS);
		n_reset <= 1'b1;
		check_idle(4);

		fd = $fopen("fill_tests.txt", "r");
		if (fd == 0)
			report_error("cannot open fill_tests.txt");

		jobs = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h", f_mode, f_colour,
				f_base, f_x_off, f_y_off, f_x_len, f_y_len, f_count);
			// Blank line
			if (fields <= 0)
				continue;
			if (fields != 8)
				report_error("malformed job line in fill_tests.txt");
			job.mode = fill_pkg::fill_mode_t'(f_mode[0]);
			job.colour = f_colour[DW - 1:0];
			job.base = f_base[AW - 1:0];
			job.x_off = f_x_off[`FILL_CNT_W - 1:0];
			job.y_off = f_y_off[`FILL_CNT_W - 1:0];
			job.x_len = f_x_len[`FILL_CNT_W - 1:0];
			job.y_len = f_y_len[`FILL_CNT_W - 1:0];
			run_job(job, f_count);
			jobs = jobs + 1;
		end
		$fclose(fd);

		if (jobs == 0) begin
			report_error("no jobs found in fill_tests.txt");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== rect_fill_top.sv ====
// Rectangle fill engine top level
`timescale 1ns/1ps
`default_nettype none

`include "fill_consts.svh"

module rect_fill_top (
	input  logic                 clkSYS,
	input  logic                 n_reset,
	input  logic                 start,
	input  logic                 ack,
	input  fill_pkg::fill_cfg_t  cfg,
	output logic                 busy,
	output logic                 done,
	output logic                 req,
	output fill_pkg::fill_wr_t   wr_word
);

	logic                        load;
	logic                        step;
	logic                        last_col;
	logic                        last_row;
	logic [`FILL_ADDR_W - 1:0]   wr_addr;
	logic [`FILL_DATA_W - 1:0]   wr_data;

	fill_fsm u_fsm (
		.clkSYS, .n_reset, .start, .ack, .last_col, .last_row,
		.load, .step, .req, .busy, .done
	);

	rect_counter u_counter (
		.clkSYS, .n_reset, .load, .step, .cfg, .last_col, .last_row
	);

	fill_addr_gen u_addr (
		.clkSYS, .n_reset, .load, .step, .last_col, .cfg, .addr(wr_addr)
	);

	fill_pattern u_pattern (
		.clkSYS, .n_reset, .load, .step, .cfg, .data(wr_data)
	);

	// Memory port word
	assign wr_word = '{addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== fill_pattern.sv ====
// Write data source, solid colour or 18-bit LFSR pattern
`timescale 1ns/1ps
`default_nettype none

`include "fill_consts.svh"

module fill_pattern (
	input  logic                       clkSYS,
	input  logic                       n_reset,
	input  logic                       load,
	input  logic                       step,
	input  fill_pkg::fill_cfg_t        cfg,
	output logic [`FILL_DATA_W - 1:0]  data
);

	localparam int LW = 18;

	fill_pkg::fill_mode_t        mode;
	logic [`FILL_DATA_W - 1:0]   colour;
	logic [LW - 1:0]             lfsr;
	logic                        lfsr_fb;

	// XNOR feedback keeps the all-zero start state legal
	assign lfsr_fb = ~(lfsr[17] ^ lfsr[10]);

	always_ff @(posedge clkSYS, negedge n_reset) begin
		if (~n_reset) begin
			mode <= fill_pkg::FILL_SOLID;
			lfsr <= '0;
		end else if (load) begin
			mode <= cfg.mode;
			// Restart so each job repeats the same sequence
			lfsr <= '0;
		end else if (step) begin
			lfsr <= {lfsr[LW - 2:0], lfsr_fb};
		end
	end

	always_ff @(posedge clkSYS) begin
		if (load)
			colour <= cfg.colour;
	end

	// Pattern uses the upper 16 LFSR bits
	assign data = (mode == fill_pkg::FILL_PATTERN) ? lfsr[17:2] : colour;

endmodule

`default_nettype wire

// ==== fill_addr_gen.sv ====
// Row base and word address generation for the fill engine
`timescale 1ns/1ps
`default_nettype none

`include "fill_consts.svh"

module fill_addr_gen (
	input  logic                       clkSYS,
	input  logic                       n_reset,
	input  logic                       load,
	input  logic                       step,
	input  logic                       last_col,
	input  fill_pkg::fill_cfg_t        cfg,
	output logic [`FILL_ADDR_W - 1:0]  addr
);

	localparam int AW = `FILL_ADDR_W;

	logic [AW - 1:0] row_base;
	logic [AW - 1:0] start_addr;
	logic [AW - 1:0] next_base;

	// First word of the rectangle
	assign start_addr = cfg.base
		+ AW'(cfg.y_off) * AW'(`FILL_LINE_SIZE)
		+ AW'(cfg.x_off);

	// First word of the following row
	assign next_base = row_base + AW'(`FILL_LINE_SIZE);

	always_ff @(posedge clkSYS, negedge n_reset) begin
		if (~n_reset) begin
			row_base <= '0;
			addr <= '0;
		end else if (load) begin
			row_base <= start_addr;
			addr <= start_addr;
		end else if (step) begin
			if (last_col) begin
				// Wrap to the start of the next row
				row_base <= next_base;
				addr <= next_base;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rect_counter.sv ====
// Column and row down-counters with end of row and end of rectangle flags
`timescale 1ns/1ps
`default_nettype none

`include "fill_consts.svh"

module rect_counter (
	input  logic                  clkSYS,
	input  logic                  n_reset,
	input  logic                  load,
	input  logic                  step,
	input  fill_pkg::fill_cfg_t   cfg,
	output logic                  last_col,
	output logic                  last_row
);

	localparam int CW = `FILL_CNT_W;

	logic [CW - 1:0] col;
	logic [CW - 1:0] row;
	// Column reload value, kept for the whole job
	logic [CW - 1:0] col_top;

	always_ff @(posedge clkSYS, negedge n_reset) begin
		if (~n_reset) begin
			col <= '0;
			row <= '0;
			col_top <= '0;
		end else if (load) begin
			col_top <= cfg.x_len - 1'b1;
			col <= cfg.x_len - 1'b1;
			row <= cfg.y_len - 1'b1;
		end else if (step) begin
			if (col == '0) begin
				// Reload the column for the next row
				col <= col_top;
				row <= row - 1'b1;
			end else begin
				col <= col - 1'b1;
			end
		end
	end

	// Counts run down to zero
	assign last_col = (col == '0);
	assign last_row = (row == '0);

endmodule

`default_nettype wire

// ==== fill_fsm.sv ====
// Job sequencer: load, write request, step and done
`timescale 1ns/1ps
`default_nettype none

module fill_fsm (
	input  logic clkSYS,
	input  logic n_reset,
	input  logic start,
	input  logic ack,
	input  logic last_col,
	input  logic last_row,
	output logic load,
	output logic step,
	output logic req,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_ISSUE  = 2'd1,
		ST_SETTLE = 2'd2
	} state_t;

	state_t state, state_next;
	logic   last_word;

	// Current word closes the rectangle
	assign last_word = last_col & last_row;

	always_comb begin
		state_next = state;
		load = 1'b0;
		step = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start) begin
					load = 1'b1;
					state_next = ST_ISSUE;
				end
			end
			ST_ISSUE: begin
				if (ack) begin
					step = 1'b1;
					state_next = last_word ? ST_IDLE : ST_SETTLE;
				end
			end
			// One gap cycle so address and data can advance
			ST_SETTLE: state_next = ST_ISSUE;
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clkSYS, negedge n_reset) begin
		if (~n_reset) begin
			state <= ST_IDLE;
			done <= 1'b0;
		end else begin
			state <= state_next;
			done <= (state == ST_ISSUE) & ack & last_word;
		end
	end

	// Request held through the whole issue state until ack
	assign req = (state == ST_ISSUE);
	assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// ==== fill_pkg.sv ====
// Fill mode, job configuration and memory write word types
`default_nettype none

`include "fill_consts.svh"

package fill_pkg;

	// Source of the write data
	typedef enum logic {
		FILL_SOLID   = 1'b0,
		FILL_PATTERN = 1'b1
	} fill_mode_t;

	// Per-job configuration, sampled in the start cycle
	typedef struct packed {
		fill_mode_t                 mode;
		// Solid mode colour
		logic [`FILL_DATA_W - 1:0]  colour;
		// Frame buffer base address
		logic [`FILL_ADDR_W - 1:0]  base;
		// Rectangle origin inside the frame
		logic [`FILL_CNT_W - 1:0]   x_off;
		logic [`FILL_CNT_W - 1:0]   y_off;
		// Rectangle size in words and rows, never zero
		logic [`FILL_CNT_W - 1:0]   x_len;
		logic [`FILL_CNT_W - 1:0]   y_len;
	} fill_cfg_t;

	// One write on the memory port
	typedef struct packed {
		logic [`FILL_ADDR_W - 1:0]  addr;
		logic [`FILL_DATA_W - 1:0]  data;
	} fill_wr_t;

endpackage

`default_nettype wire

// ==== fill_consts.svh ====
// Width and pitch macros for the rectangle fill engine
`ifndef FILL_CONSTS_SVH
`define FILL_CONSTS_SVH

// Word address into the frame buffer memory
`define FILL_ADDR_W 24

// One memory word, also one pixel
`define FILL_DATA_W 16

// Column and row counters
// Also the width of offsets and lengths in the job configuration
`define FILL_CNT_W 10

// Line pitch in words
// Distance between the first words of two adjacent rows
`define FILL_LINE_SIZE 480

// Largest rectangle dimension that the counters can hold
// is 2 ** FILL_CNT_W - 1 words
// Zero length is not supported

// The memory port carries a fill_wr_t,
// FILL_ADDR_W + FILL_DATA_W bits wide,
// with the address in the upper bits

`endif
